// ==== hw/hdmi_island_pkg.sv ====
package hdmi_island_pkg;

    // Packet type codes as sent in header byte 0
    typedef enum logic [7:0] {
        pkt_null          = 8'h00,
        pkt_audio_sample  = 8'h02,
        pkt_avi_infoframe = 8'h82
    } packet_type_e;

    // Phases of one data island, in the order they occur
    typedef enum logic [2:0] {
        st_idle,
        st_preamble,
        st_lead_guard,
        st_packet,
        st_trail_guard
    } island_state_e;

    localparam int packet_cycles   = 32; // Pixel clocks per packet
    localparam int preamble_cycles = 8;  // Control period preamble ahead of the island
    localparam int guard_cycles    = 2;  // Guard band length on each side of the packets
    localparam int max_packets     = 18; // Upper bound on packets per island

    // Bits of each BCH block that carry data, the rest is ECC
    localparam int header_bits    = 24;
    localparam int subpacket_bits = 56;

    // BCH(64,56) and BCH(32,24) generator, applied LSB first
    localparam logic [7:0] ecc_poly = 8'h83;

    localparam int iec_frames = 192; // Frames per IEC 60958 channel status block

    // AVI InfoFrame header fields
    localparam int avi_version = 2;
    localparam int avi_length  = 13;

endpackage

// ==== hw/island_scheduler.sv ====
`timescale 1ns/1ps

module island_scheduler
    import hdmi_island_pkg::*;
(
    input  logic clk_pixel,
    input  logic rst_n,
    input  logic island_request, // Blanking available from video timing
    output logic preamble,
    output logic guard,
    output logic data_island_period,
    output logic packet_start     // Picker latch strobe, one cycle ahead of each packet
);

    island_state_e state;
    logic [4:0]    cycle_cnt;     // Position inside the current phase
    logic [4:0]    pkt_cnt;       // Packets already finished in this island
    logic          more_packets;  // Another packet follows the current one
    logic          phase_end;

    // Continue while blanking lasts and the packet limit is not reached
    assign more_packets = island_request && (pkt_cnt != 5'(max_packets - 1));

    always_comb
    begin
        case (state)
            st_preamble:    phase_end = (cycle_cnt == 5'(preamble_cycles - 1));
            st_lead_guard:  phase_end = (cycle_cnt == 5'(guard_cycles - 1));
            st_packet:      phase_end = (cycle_cnt == 5'(packet_cycles - 1));
            st_trail_guard: phase_end = (cycle_cnt == 5'(guard_cycles - 1));
            default:        phase_end = 1'b0;
        endcase
    end

    always_ff @(posedge clk_pixel or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= st_idle;
            cycle_cnt <= 5'd0;
            pkt_cnt   <= 5'd0;
        end
        else
        begin
            cycle_cnt <= phase_end ? 5'd0 : cycle_cnt + 5'd1; // Each phase restarts at 0
            case (state)
                st_idle:
                begin
                    cycle_cnt <= 5'd0; // Idle does not count
                    if (island_request)
                        state <= st_preamble;
                end
                st_preamble:
                    if (phase_end)
                        state <= st_lead_guard;
                st_lead_guard:
                    if (phase_end)
                    begin
                        state   <= st_packet;
                        pkt_cnt <= 5'd0;
                    end
                st_packet:
                    if (phase_end)
                    begin
                        if (more_packets)
                            pkt_cnt <= pkt_cnt + 5'd1; // Stay for the next slot
                        else
                            state <= st_trail_guard;
                    end
                st_trail_guard:
                    if (phase_end)
                        state <= st_idle;
                default:
                    state <= st_idle;
            endcase
        end
    end

    assign preamble           = (state == st_preamble);
    assign guard              = (state == st_lead_guard) || (state == st_trail_guard);
    assign data_island_period = (state == st_packet);

    // The picker output lags its strobe by one cycle, so pulse in the cycle before each packet
    assign packet_start = ((state == st_lead_guard) && phase_end)
                       || ((state == st_packet) && phase_end && more_packets);

endmodule

// ==== hw/packet_picker.sv ====
`timescale 1ns/1ps

module packet_picker
    import hdmi_island_pkg::*;
(
    input  logic         clk_pixel,
    input  logic         rst_n,
    input  logic         packet_start,
    input  logic         frame_start,
    input  logic         audio_valid,
    input  logic [23:0]  audio_left,
    input  logic [23:0]  audio_right,
    input  logic [103:0] avi_payload,   // Data bytes 1 to 13, byte 1 in the low bits
    input  logic [7:0]   frame_counter,
    output packet_type_e packet_type,
    output logic [23:0]  header,
    output logic [55:0]  sub [3:0]
);

    logic         audio_pending;      // Stereo sample waiting for a packet
    logic         avi_pending;        // InfoFrame owed for the current video frame
    logic [23:0]  sample_left;
    logic [23:0]  sample_right;
    logic [5:0]   since_latch;        // Cycles since the last latch, saturating
    logic [7:0]   frame_count_next;   // IEC frame number the next packet will carry
    logic         b_flag;
    logic [7:0]   byte_sum;
    logic [7:0]   checksum;
    packet_type_e sel_type;
    logic [23:0]  header_next;
    logic [55:0]  sub_next [3:0];

    // Audio wins over the InfoFrame, null fills the rest
    always_comb
    begin
        if (audio_pending)
            sel_type = pkt_audio_sample;
        else if (avi_pending)
            sel_type = pkt_avi_infoframe;
        else
            sel_type = pkt_null;
    end

    // A strobe exactly one packet after the last latch ends an audio packet in flight.
    // The assembler bumps its count on that same edge, so look one frame ahead
    always_comb
    begin
        if ((since_latch == 6'(packet_cycles - 1)) && (packet_type == pkt_audio_sample))
            frame_count_next = (frame_counter == 8'(iec_frames - 1)) ? 8'd0 : frame_counter + 8'd1;
        else
            frame_count_next = frame_counter;
    end

    assign b_flag = (frame_count_next == 8'd0); // Start of a channel status block

    // The checksum cancels the header bytes and all payload bytes modulo 256
    always_comb
    begin
        byte_sum = 8'(pkt_avi_infoframe) + 8'(avi_version) + 8'(avi_length);
        for (int i = 0; i < avi_length; i++)
            byte_sum = byte_sum + avi_payload[8*i +: 8];
        checksum = 8'd0 - byte_sum;
    end

    always_comb
    begin
        header_next = 24'd0; // Null packet is all zero
        sub_next    = '{default: 56'd0};
        case (sel_type)
            pkt_audio_sample:
            begin
                // HB1 says layout 0 with only subpacket 0 present, HB2 bit 4 is B.0
                header_next = {3'b000, b_flag, 4'b0000, 8'h01, 8'(pkt_audio_sample)};
                // V, U and C stay 0, so the even parity covers just the sample bits
                sub_next[0] = {^sample_right, 3'b000, ^sample_left, 3'b000,
                               sample_right, sample_left};
            end
            pkt_avi_infoframe:
            begin
                header_next = {8'(avi_length), 8'(avi_version), 8'(pkt_avi_infoframe)};
                sub_next[0] = {avi_payload[47:0], checksum};  // Checksum then data bytes 1 to 6
                sub_next[1] = avi_payload[103:48];            // Data bytes 7 to 13
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_pixel or negedge rst_n)
    begin
        if (!rst_n)
        begin
            audio_pending <= 1'b0;
            avi_pending   <= 1'b0;
            packet_type   <= pkt_null;
            since_latch   <= 6'h3f;
        end
        else
        begin
            if (packet_start)
            begin
                packet_type <= sel_type;
                if (sel_type == pkt_audio_sample)
                    audio_pending <= 1'b0;
                if (sel_type == pkt_avi_infoframe)
                    avi_pending <= 1'b0;
            end
            if (audio_valid)
                audio_pending <= 1'b1; // A fresh sample stays pending even on a latch cycle
            if (frame_start)
                avi_pending <= 1'b1;
            if (packet_start)
                since_latch <= 6'd0;
            else if (since_latch != 6'h3f)
                since_latch <= since_latch + 6'd1;
        end
    end

    // Newer samples overwrite a pending one
    always_ff @(posedge clk_pixel)
    begin
        if (audio_valid)
        begin
            sample_left  <= audio_left;
            sample_right <= audio_right;
        end
    end

    always_ff @(posedge clk_pixel)
    begin
        if (packet_start)
        begin
            header <= header_next;
            sub    <= sub_next;
        end
    end

endmodule

// ==== hw/packet_assembler.sv ====
`timescale 1ns/1ps

module packet_assembler
    import hdmi_island_pkg::*;
(
    input  logic         clk_pixel,
    input  logic         rst_n,
    input  logic         data_island_period,
    input  packet_type_e packet_type,
    input  logic [23:0]  header,
    input  logic [55:0]  sub [3:0],
    output logic [8:0]   packet_data,   // Lane 0 header block, lanes 1 to 8 subpacket pairs
    output logic [7:0]   frame_counter  // IEC 60958 frame of the current audio sample
);

    logic [4:0] counter;          // Bit slot inside the packet
    logic [5:0] bit_even;         // Subpacket bit sent on lanes 1 to 4
    logic [5:0] bit_odd;          // Subpacket bit sent on lanes 5 to 8
    logic [7:0] parity [4:0];     // Entry 4 protects the header
    logic [7:0] hdr_step;
    logic [7:0] sub_step1 [3:0];
    logic [7:0] sub_step2 [3:0];
    logic [31:0] bch4;
    logic [63:0] bch [3:0];

    assign bit_even = {counter, 1'b0};
    assign bit_odd  = {counter, 1'b1};

    // One LSB first LFSR step of the BCH encoder
    function automatic logic [7:0] next_ecc(input logic [7:0] ecc, input logic data_bit);
        if (ecc[0] ^ data_bit)
            return (ecc >> 1) ^ ecc_poly;
        return ecc >> 1;
    endfunction

    // Subpackets move two bits per cycle, so their parity needs two steps each cycle
    always_comb
    begin
        hdr_step = next_ecc(parity[4], header[counter]);
        for (int i = 0; i < 4; i++)
        begin
            sub_step1[i] = next_ecc(parity[i], sub[i][bit_even]);
            sub_step2[i] = next_ecc(sub_step1[i], sub[i][bit_odd]);
        end
    end

    // Parity rides behind the data, so bit 24 or pair 56 onwards reads out the ECC
    always_comb
    begin
        bch4 = {parity[4], header};
        packet_data[0] = bch4[counter];
        for (int i = 0; i < 4; i++)
        begin
            bch[i]             = {parity[i], sub[i]};
            packet_data[1 + i] = bch[i][bit_even];
            packet_data[5 + i] = bch[i][bit_odd];
        end
    end

    always_ff @(posedge clk_pixel or negedge rst_n)
    begin
        if (!rst_n)
        begin
            counter       <= 5'd0;
            parity        <= '{default: 8'd0};
            frame_counter <= 8'd0;
        end
        else if (data_island_period)
        begin
            counter <= counter + 5'd1; // Wraps to 0 at each packet boundary
            if (bit_odd < 6'(subpacket_bits))
                parity[3:0] <= sub_step2; // ECC is computed over data bits only
            if (counter < 5'(header_bits))
                parity[4] <= hdr_step;
            else if (counter == 5'(packet_cycles - 1))
            begin
                parity <= '{default: 8'd0}; // Fresh ECC for the next packet
                if (packet_type == pkt_audio_sample)
                    frame_counter <= (frame_counter == 8'(iec_frames - 1)) ? 8'd0
                                                                         : frame_counter + 8'd1;
            end
        end
    end

endmodule

// ==== hw/hdmi_island_top.sv ====
`timescale 1ns/1ps

module hdmi_island_top
    import hdmi_island_pkg::*;
(
    input  logic         clk_pixel,
    input  logic         rst_n,
    input  logic         island_request,
    input  logic         frame_start,
    input  logic         audio_valid,
    input  logic [23:0]  audio_left,
    input  logic [23:0]  audio_right,
    input  logic [103:0] avi_payload,
    output logic         preamble,
    output logic         guard,
    output logic         data_island_period,
    output logic [8:0]   packet_data,
    output logic [7:0]   frame_counter
);

    logic         packet_start;
    packet_type_e packet_type;
    logic [23:0]  header;
    logic [55:0]  sub [3:0];

    // Framing of the island and the latch strobes for the picker
    island_scheduler scheduler_i (
        .clk_pixel          (clk_pixel),
        .rst_n              (rst_n),
        .island_request     (island_request),
        .preamble           (preamble),
        .guard              (guard),
        .data_island_period (data_island_period),
        .packet_start       (packet_start)
    );

    packet_picker picker_i (
        .clk_pixel     (clk_pixel),
        .rst_n         (rst_n),
        .packet_start  (packet_start),
        .frame_start   (frame_start),
        .audio_valid   (audio_valid),
        .audio_left    (audio_left),
        .audio_right   (audio_right),
        .avi_payload   (avi_payload),
        .frame_counter (frame_counter), // Feeds the B flag of the next sample
        .packet_type   (packet_type),
        .header        (header),
        .sub           (sub)
    );

    packet_assembler assembler_i (
        .clk_pixel          (clk_pixel),
        .rst_n              (rst_n),
        .data_island_period (data_island_period),
        .packet_type        (packet_type),
        .header             (header),
        .sub                (sub),
        .packet_data        (packet_data),
        .frame_counter      (frame_counter)
    );

endmodule

// ==== verif/hdmi_island_sva.sv ====
`timescale 1ns/1ps

module hdmi_island_sva
    import hdmi_island_pkg::*;
(
    input logic clk_pixel,
    input logic rst_n,
    input logic preamble,
    input logic guard,
    input logic data_island_period
);

    logic [9:0] packet_run; // Data island cycles in the current island so far

    always_ff @(posedge clk_pixel or negedge rst_n)
    begin
        if (!rst_n)
            packet_run <= 10'd0;
        else if (data_island_period)
            packet_run <= packet_run + 10'd1;
        else
            packet_run <= 10'd0;
    end

    preamble_length: assert property (@(posedge clk_pixel) disable iff (!rst_n)
        $rose(preamble) |-> preamble [*preamble_cycles] ##1 !preamble)
        else $error("Preamble did not last %0d cycles", preamble_cycles);

    guard_length: assert property (@(posedge clk_pixel) disable iff (!rst_n)
        $rose(guard) |-> guard [*guard_cycles] ##1 !guard)
        else $error("Guard band did not last %0d cycles", guard_cycles);

    // Guard bands sit outside the packets and hand over at both ends of the run
    guard_data_apart: assert property (@(posedge clk_pixel) disable iff (!rst_n)
        $changed(data_island_period) |-> $changed(guard) && !(guard && data_island_period))
        else $error("Guard band does not border the data island period");

    packet_multiple: assert property (@(posedge clk_pixel) disable iff (!rst_n)
        $fell(data_island_period) |-> (packet_run % packet_cycles == 0) && (packet_run != 0)
                                      && (packet_run <= packet_cycles * max_packets))
        else $error("Data island period of %0d cycles is not whole packets", packet_run);

endmodule

bind island_scheduler hdmi_island_sva sva_i (
    .clk_pixel          (clk_pixel),
    .rst_n              (rst_n),
    .preamble           (preamble),
    .guard              (guard),
    .data_island_period (data_island_period)
);

// ==== verif/tb_hdmi_island.sv ====
`timescale 1ns/1ps

module tb_hdmi_island
    import hdmi_island_pkg::*;
();

    localparam int num_islands     = 50;
    localparam int island_worst    = preamble_cycles + 2 * guard_cycles
                                   + packet_cycles * max_packets;
    localparam int watchdog_cycles = 3 + num_islands * (island_worst + 40) + 200;

    logic         clk_pixel = 1'b0;
    logic         rst_n;
    logic         island_request;
    logic         frame_start;
    logic         audio_valid;
    logic [23:0]  audio_left;
    logic [23:0]  audio_right;
    logic [103:0] avi_payload;
    logic         preamble;
    logic         guard;
    logic         data_island_period;
    logic [8:0]   packet_data;
    logic [7:0]   frame_counter;

    // Mirror of the picker state during the current cycle
    logic         audio_pending  = 1'b0;
    logic         avi_pending    = 1'b0;
    logic [23:0]  sample_left    = 24'd0;
    logic [23:0]  sample_right   = 24'd0;
    logic         snap_audio     = 1'b0; // Same state one cycle earlier, the possible latch cycle
    logic         snap_avi       = 1'b0;
    logic [23:0]  snap_left      = 24'd0;
    logic [23:0]  snap_right     = 24'd0;
    logic         audio_set_prev = 1'b0; // Strobes seen on that latch edge
    logic         avi_set_prev   = 1'b0;
    int           fc_model       = 0;

    logic [2:0]   code;
    logic [2:0]   last_code      = 3'b000; // {preamble, guard, data_island_period}
    int           run_len        = 0;
    int           pos            = 0;      // Bit slot inside the packet
    int           pkt_idx        = 0;
    logic         continue_known = 1'b0;
    logic         more_expected  = 1'b0;

    logic [31:0]  rx_header;
    logic [63:0]  rx_sub [4];
    packet_type_e exp_type;
    logic [247:0] exp_packet; // Subpackets 3 to 0 above the 24 header bits
    logic [7:0]   exp_fc;
    logic [7:0]   seen_fc;
    logic [7:0]   byte_sum;
    int           audio_packets  = 0;
    int           avi_packets    = 0;
    int           null_packets   = 0;
    event         packet_done;

    always #10 clk_pixel = ~clk_pixel;

    hdmi_island_top dut_i (
        .clk_pixel          (clk_pixel),
        .rst_n              (rst_n),
        .island_request     (island_request),
        .frame_start        (frame_start),
        .audio_valid        (audio_valid),
        .audio_left         (audio_left),
        .audio_right        (audio_right),
        .avi_payload        (avi_payload),
        .preamble           (preamble),
        .guard              (guard),
        .data_island_period (data_island_period),
        .packet_data        (packet_data),
        .frame_counter      (frame_counter)
    );

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] seen);
        if (seen !== expected)
        begin
            $display("ERROR at %0t: %s expected 0x%0h, seen 0x%0h", $time, name, expected, seen);
            $display("TB FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // BCH ECC shifted in LSB first, as the HDMI island blocks are sent
    function automatic logic [7:0] bch_ecc(input logic [55:0] data, input int nbits);
        logic [7:0] ecc;
        logic       feedback;
        ecc = 8'd0;
        for (int i = 0; i < nbits; i++)
        begin
            feedback = ecc[0] ^ data[i];
            ecc      = ecc >> 1;
            if (feedback)
                ecc = ecc ^ ecc_poly;
        end
        return ecc;
    endfunction

    // Header bytes, checksum and payload add up to zero modulo 256
    function automatic logic [7:0] avi_checksum(input logic [103:0] payload);
        logic [7:0] sum;
        sum = 8'h82 + 8'(avi_version) + 8'(avi_length);
        for (int i = 0; i < 13; i++)
            sum = sum + payload[8*i +: 8];
        return 8'd0 - sum;
    endfunction

    function automatic logic [247:0] expected_packet(input packet_type_e ptype, input logic b_flag,
                                                     input logic [23:0] left,
                                                     input logic [23:0] right,
                                                     input logic [103:0] payload);
        logic [23:0]       hdr;
        logic [3:0][55:0]  sp;
        hdr = 24'd0;
        sp  = '0;
        case (ptype)
            pkt_audio_sample:
            begin
                hdr          = {3'b000, b_flag, 4'b0000, 8'h01, 8'h02}; // B.0 in HB2 bit 4
                sp[0][23:0]  = left;
                sp[0][47:24] = right;
                sp[0][51]    = ^left;  // Even parity, V, U and C are all zero
                sp[0][55]    = ^right;
            end
            pkt_avi_infoframe:
            begin
                hdr   = {8'(avi_length), 8'(avi_version), 8'h82};
                sp[0] = {payload[47:0], avi_checksum(payload)};
                sp[1] = payload[103:48];
            end
            default: ;
        endcase
        return {sp, hdr};
    endfunction

    task automatic drive_audio();
        forever
        begin
            repeat ($urandom_range(70, 20)) @(posedge clk_pixel);
            audio_valid <= 1'b1;
            audio_left  <= 24'($urandom);
            audio_right <= 24'($urandom);
            @(posedge clk_pixel);
            audio_valid <= 1'b0;
        end
    endtask

    task automatic drive_frame_start();
        forever
        begin
            repeat ($urandom_range(1200, 400)) @(posedge clk_pixel);
            frame_start <= 1'b1;
            @(posedge clk_pixel);
            frame_start <= 1'b0;
        end
    endtask

    // Capture at the falling edge where outputs and driven inputs are settled
    always @(negedge clk_pixel)
    begin
        if (rst_n)
        begin
            code = {preamble, guard, data_island_period};
            if (code != last_code)
            begin
                if (last_code == 3'b100)
                    check_value("preamble cycles", preamble_cycles, run_len);
                if (last_code == 3'b010)
                    check_value("guard cycles", guard_cycles, run_len);
                run_len = 0;
            end
            run_len++;
            last_code = code;
            if (preamble)
                pkt_idx = 0;
            if (continue_known)
            begin
                check_value("data_island_period", more_expected, data_island_period);
                check_value("guard", !more_expected, guard);
                continue_known = 1'b0;
            end
            if (data_island_period)
            begin
                if (pos == 0) // The previous edge latched this packet
                begin
                    if (snap_audio)
                    begin
                        exp_type      = pkt_audio_sample;
                        audio_pending = audio_set_prev; // A strobe on the latch edge survives
                    end
                    else if (snap_avi)
                    begin
                        exp_type    = pkt_avi_infoframe;
                        avi_pending = avi_set_prev;
                    end
                    else
                        exp_type = pkt_null;
                    exp_fc     = 8'(fc_model);
                    seen_fc    = frame_counter;
                    exp_packet = expected_packet(exp_type, fc_model == 0, snap_left, snap_right,
                                                 avi_payload);
                    if (exp_type == pkt_audio_sample)
                        fc_model = (fc_model == iec_frames - 1) ? 0 : fc_model + 1;
                end
                rx_header[pos] = packet_data[0];
                for (int i = 0; i < 4; i++)
                begin
                    rx_sub[i][2*pos]     = packet_data[1 + i];
                    rx_sub[i][2*pos + 1] = packet_data[5 + i];
                end
                if (pos == packet_cycles - 1)
                begin
                    more_expected  = island_request && (pkt_idx < max_packets - 1);
                    continue_known = 1'b1;
                    pkt_idx++;
                    -> packet_done;
                end
                pos = (pos + 1) % packet_cycles;
            end
            snap_audio     = audio_pending;
            snap_avi       = avi_pending;
            snap_left      = sample_left;
            snap_right     = sample_right;
            audio_set_prev = audio_valid;
            avi_set_prev   = frame_start;
            if (audio_valid)
            begin
                audio_pending = 1'b1;
                sample_left   = audio_left;
                sample_right  = audio_right;
            end
            if (frame_start)
                avi_pending = 1'b1;
        end
    end

    always @(packet_done)
    begin
        check_value("frame_counter", exp_fc, seen_fc);
        check_value("header", exp_packet[23:0], rx_header[23:0]);
        check_value("header ecc", bch_ecc(56'(rx_header[23:0]), 24), rx_header[31:24]);
        for (int i = 0; i < 4; i++)
        begin
            check_value($sformatf("sub[%0d]", i), exp_packet[24 + 56*i +: 56], rx_sub[i][55:0]);
            check_value($sformatf("sub[%0d] ecc", i), bch_ecc(rx_sub[i][55:0], 56),
                        rx_sub[i][63:56]);
        end
        case (exp_type)
            pkt_audio_sample:
                audio_packets++;
            pkt_avi_infoframe:
            begin
                byte_sum = rx_header[7:0] + rx_header[15:8] + rx_header[23:16];
                for (int i = 0; i < 7; i++)
                    byte_sum = byte_sum + rx_sub[0][8*i +: 8] + rx_sub[1][8*i +: 8];
                check_value("infoframe byte sum", 0, byte_sum);
                avi_packets++;
            end
            default:
                null_packets++;
        endcase
    end

    initial
    begin
        repeat (watchdog_cycles) @(posedge clk_pixel);
        $display("Timeout: the islands did not finish within %0d clock cycles", watchdog_cycles);
        $display("TB FAILED");
        $fatal(1, "Watchdog expired");
    end

    initial
    begin
        int seed_value;
        int packets;
        int hold;
        seed_value     = $urandom(17946);
        rst_n          = 1'b0;
        island_request = 1'b0;
        frame_start    = 1'b0;
        audio_valid    = 1'b0;
        audio_left     = 24'd0;
        audio_right    = 24'd0;
        avi_payload    = 104'({$urandom, $urandom, $urandom, $urandom}); // Static for the run
        repeat (3) @(posedge clk_pixel);
        rst_n <= 1'b1;
        fork
            drive_audio();
            drive_frame_start();
        join_none
        for (int k = 0; k < num_islands; k++)
        begin
            packets = $urandom_range(max_packets + 1, 1);
            // Drop inside packet n so n packets go out, or past the cap but before idle
            hold = (packets > max_packets) ? island_worst : packet_cycles * packets - 6;
            island_request <= 1'b1;
            repeat (hold) @(posedge clk_pixel);
            island_request <= 1'b0;
            @(posedge clk_pixel);
            while (preamble || guard || data_island_period)
                @(posedge clk_pixel);
            repeat ($urandom_range(20, 2)) @(posedge clk_pixel);
        end
        if (audio_packets <= iec_frames || avi_packets == 0 || null_packets == 0)
        begin
            $display("Too few packets of some type: %0d audio, %0d InfoFrame, %0d null",
                     audio_packets, avi_packets, null_packets);
            $display("TB FAILED");
            $fatal(1, "Packet mix incomplete");
        end
        else
        begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

// ==== verilog.f ====
hw/hdmi_island_pkg.sv
hw/island_scheduler.sv
hw/packet_picker.sv
hw/packet_assembler.sv
hw/hdmi_island_top.sv
verif/hdmi_island_sva.sv
verif/tb_hdmi_island.sv

// ==== Bender.yml ====
package:
  name: hdmi_island

sources:
  - files:
      - hw/hdmi_island_pkg.sv
      - hw/island_scheduler.sv
      - hw/packet_picker.sv
      - hw/packet_assembler.sv
      - hw/hdmi_island_top.sv
  - target: test
    files:
      - verif/hdmi_island_sva.sv
      - verif/tb_hdmi_island.sv
